// File: logic/periph_pkg.sv
// ---------------------------------------------------------------------
// Peripheral subsystem shared definitions
// ---------------------------------------------------------------------

package periph_pkg;

	// bus widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 32;

	// ---------------------------------------------------------------------
	// address map
	// ---------------------------------------------------------------------
	localparam int N_SLAVES = 2;
	localparam int SEL_HI = 15;
	localparam int SEL_LO = 12;
	localparam int WIN_TIMER = 0;
	localparam int WIN_TIMEBASE = 1;

	// timer register byte offsets within its window
	localparam logic [SEL_LO-1:0] TMR_CTRL = 12'h000;
	localparam logic [SEL_LO-1:0] TMR_MTIME = 12'h008;
	localparam logic [SEL_LO-1:0] TMR_MTIMEH = 12'h00c;
	localparam logic [SEL_LO-1:0] TMR_MTIMECMP = 12'h010;
	localparam logic [SEL_LO-1:0] TMR_MTIMECMPH = 12'h014;

	// timebase
	localparam logic [SEL_LO-1:0] TB_DIV = 12'h000;
	localparam int DIV_W = 8;
	localparam logic [DIV_W-1:0] DIV_RESET = 8'd4;

	localparam int MTIME_W = 64;

	// ---------------------------------------------------------------------
	// APB request and response
	// ---------------------------------------------------------------------
	typedef struct packed {
		logic              sel;
		logic              enable;
		logic              write;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} apb_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic              ready;
		logic              slverr;
	} apb_rsp_t;

endpackage

// File: logic/apb_decoder.sv
// ---------------------------------------------------------------------
// APB address decoder
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module apb_decoder (
	input  periph_pkg::apb_req_t                          req,
	output periph_pkg::apb_rsp_t                          rsp,
	output periph_pkg::apb_req_t [periph_pkg::N_SLAVES-1:0] slv_req,
	input  periph_pkg::apb_rsp_t [periph_pkg::N_SLAVES-1:0] slv_rsp
);

	// window number from the upper address bits
	logic [periph_pkg::SEL_HI-periph_pkg::SEL_LO:0] win;
	logic                                           hit;

	assign win = req.addr[periph_pkg::SEL_HI:periph_pkg::SEL_LO];

	// ---------------------------------------------------------------------
	// request fan-out
	// ---------------------------------------------------------------------
	always_comb begin
		for (int i = 0; i < periph_pkg::N_SLAVES; i++) begin
			slv_req[i] = req;
			// only the addressed slave sees sel
			slv_req[i].sel = req.sel && (win == i);
		end
	end

	// ---------------------------------------------------------------------
	// response merge
	// ---------------------------------------------------------------------
	always_comb begin
		hit = 1'b0;
		for (int i = 0; i < periph_pkg::N_SLAVES; i++) begin
			if (win == i) begin
				hit = 1'b1;
			end
		end
	end

	always_comb begin
		// unmapped window, decoder answers by itself
		rsp.rdata = '0;
		rsp.ready = 1'b1;
		rsp.slverr = 1'b1;
		if (hit) begin
			for (int i = 0; i < periph_pkg::N_SLAVES; i++) begin
				if (win == i) begin
					rsp = slv_rsp[i];
				end
			end
		end
	end

endmodule

// File: logic/timebase.sv
// ---------------------------------------------------------------------
// Programmable timer tick divider
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module timebase (
	input  logic                 clk,
	input  logic                 rst_n,
	input  periph_pkg::apb_req_t req,
	output periph_pkg::apb_rsp_t rsp,
	output logic                 tick
);

	logic [periph_pkg::DIV_W-1:0] div_q;
	logic [periph_pkg::DIV_W-1:0] cnt_q;
	logic [periph_pkg::DIV_W-1:0] reload;
	logic                         div_hit;
	logic                         div_wr;

	assign div_hit = req.addr[periph_pkg::SEL_LO-1:0] == periph_pkg::TB_DIV;
	assign div_wr = req.sel && req.enable && req.write && div_hit;

	// a divider of zero behaves like one
	assign reload = (div_q == '0) ? '0 : div_q - 1'b1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_q <= periph_pkg::DIV_RESET;
		end else if (div_wr) begin
			div_q <= req.wdata[periph_pkg::DIV_W-1:0];
		end
	end

	// down-counter, new divider only picked up on reload
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q <= '0;
			tick <= 1'b0;
		end else begin
			tick <= cnt_q == '0;
			if (cnt_q == '0) begin
				cnt_q <= reload;
			end else begin
				cnt_q <= cnt_q - 1'b1;
			end
		end
	end

	always_comb begin
		rsp.rdata = '0;
		if (div_hit) begin
			rsp.rdata[periph_pkg::DIV_W-1:0] = div_q;
		end
		rsp.ready = 1'b1;
		rsp.slverr = 1'b0;
	end

endmodule

// File: logic/mtimer.sv
// ---------------------------------------------------------------------
// Machine timer with APB registers
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module mtimer (
	input  logic                 clk,
	input  logic                 rst_n,
	input  periph_pkg::apb_req_t req,
	output periph_pkg::apb_rsp_t rsp,
	input  logic                 tick,
	input  logic                 dbg_halt,
	output logic                 timer_irq
);

	logic [periph_pkg::MTIME_W-1:0] mtime_q;
	logic [periph_pkg::MTIME_W-1:0] cmp_q;
	logic                           en_q;

	logic [periph_pkg::SEL_LO-1:0] ofs;
	logic                          wr;
	logic                          wr_ctrl;
	logic                          wr_time_lo;
	logic                          wr_time_hi;
	logic                          wr_cmp_lo;
	logic                          wr_cmp_hi;
	logic                          count_en;

	assign ofs = req.addr[periph_pkg::SEL_LO-1:0];

	// write completes on the access-phase edge, ready is always high
	assign wr = req.sel && req.enable && req.write;

	// ---------------------------------------------------------------------
	// write decode
	// ---------------------------------------------------------------------
	always_comb begin
		wr_ctrl = 1'b0;
		wr_time_lo = 1'b0;
		wr_time_hi = 1'b0;
		wr_cmp_lo = 1'b0;
		wr_cmp_hi = 1'b0;
		if (wr) begin
			case (ofs)
				periph_pkg::TMR_CTRL:      wr_ctrl = 1'b1;
				periph_pkg::TMR_MTIME:     wr_time_lo = 1'b1;
				periph_pkg::TMR_MTIMEH:    wr_time_hi = 1'b1;
				periph_pkg::TMR_MTIMECMP:  wr_cmp_lo = 1'b1;
				periph_pkg::TMR_MTIMECMPH: wr_cmp_hi = 1'b1;
				default: ;
			endcase
		end
	end

	// frozen while the core is halted in debug
	assign count_en = tick && en_q && !dbg_halt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			en_q <= 1'b1;
		end else if (wr_ctrl) begin
			en_q <= req.wdata[0];
		end
	end

	// ---------------------------------------------------------------------
	// mtime and mtimecmp
	// ---------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime_q <= '0;
		end else if (wr_time_lo) begin
			mtime_q[31:0] <= req.wdata;
		end else if (wr_time_hi) begin
			mtime_q[63:32] <= req.wdata;
		end else if (count_en) begin
			mtime_q <= mtime_q + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmp_q <= '1;
		end else if (wr_cmp_lo) begin
			cmp_q[31:0] <= req.wdata;
		end else if (wr_cmp_hi) begin
			cmp_q[63:32] <= req.wdata;
		end
	end

	// unsigned 64-bit compare, registered
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer_irq <= 1'b0;
		end else begin
			timer_irq <= mtime_q >= cmp_q;
		end
	end

	// ---------------------------------------------------------------------
	// read mux
	// ---------------------------------------------------------------------
	always_comb begin
		rsp.rdata = '0;
		case (ofs)
			periph_pkg::TMR_CTRL:      rsp.rdata[0] = en_q;
			periph_pkg::TMR_MTIME:     rsp.rdata = mtime_q[31:0];
			periph_pkg::TMR_MTIMEH:    rsp.rdata = mtime_q[63:32];
			periph_pkg::TMR_MTIMECMP:  rsp.rdata = cmp_q[31:0];
			periph_pkg::TMR_MTIMECMPH: rsp.rdata = cmp_q[63:32];
			default: ;
		endcase
		rsp.ready = 1'b1;
		rsp.slverr = 1'b0;
	end

endmodule

// File: logic/periph_subsys.sv
// ---------------------------------------------------------------------
// Peripheral subsystem top level
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module periph_subsys (
	input  logic                 clk,
	input  logic                 rst_n,
	input  periph_pkg::apb_req_t req,
	output periph_pkg::apb_rsp_t rsp,
	input  logic                 dbg_halt,
	output logic                 timer_irq
);

	periph_pkg::apb_req_t [periph_pkg::N_SLAVES-1:0] slv_req;
	periph_pkg::apb_rsp_t [periph_pkg::N_SLAVES-1:0] slv_rsp;
	logic                                            tick;

	apb_decoder decoder_i (
		.req     (req),
		.rsp     (rsp),
		.slv_req (slv_req),
		.slv_rsp (slv_rsp)
	);

	// microsecond tick source
	timebase timebase_i (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (slv_req[periph_pkg::WIN_TIMEBASE]),
		.rsp   (slv_rsp[periph_pkg::WIN_TIMEBASE]),
		.tick  (tick)
	);

	mtimer mtimer_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (slv_req[periph_pkg::WIN_TIMER]),
		.rsp       (slv_rsp[periph_pkg::WIN_TIMER]),
		.tick      (tick),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq)
	);

endmodule

// File: test/tb_periph_subsys.sv
// ---------------------------------------------------------------------
// Peripheral subsystem testbench
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module tb_periph_subsys;

	localparam int CLK_PERIOD = 100;
	localparam int RST_CYC = 10;
	localparam int XFER_CYC = 3;
	localparam int DRAIN_CYC = 260;
	localparam int COUNT_N = 200;
	localparam int HOLD_CYC = 50;
	localparam int RESUME_CYC = 20;
	localparam int IRQ_WAIT = 400;
	localparam int CMP_OFFSET = 40;
	// worst-case cycles of each test
	localparam int T1_CYC = RST_CYC + 16 * XFER_CYC + 4;
	localparam int T2_CYC = 8 * XFER_CYC + 4;
	localparam int T3_CYC = DRAIN_CYC + COUNT_N + 6 * XFER_CYC + 4;
	localparam int T4_CYC = 2 * HOLD_CYC + RESUME_CYC + 12 * XFER_CYC + 4;
	localparam int T5_CYC = IRQ_WAIT + 9 * XFER_CYC + 8;
	localparam int LIMIT = (T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC) * 12 / 10;

	logic                 clk;
	logic                 rst_n;
	periph_pkg::apb_req_t req;
	periph_pkg::apb_rsp_t rsp;
	logic                 dbg_halt;
	logic                 timer_irq;

	// register model
	logic        m_en;
	logic [63:0] m_mtime;
	logic [63:0] m_cmp;
	logic [7:0]  m_div;

	logic [31:0] rng_state;
	logic [31:0] xfer_rdata;
	logic        xfer_err;
	int          cycles;
	int          err_cnt;
	int          check_cnt;
	int          test_cnt;
	int          test_fail;
	int          err_start;
	string       cur_test;
	string       name_q[$];
	logic [63:0] exp_q[$];
	logic [63:0] act_q[$];
	string       cmp_name;
	logic [63:0] cmp_exp;
	logic [63:0] cmp_act;

	periph_subsys dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.rsp       (rsp),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// drain queued results and compare
	always @(posedge clk) begin
		while (exp_q.size() != 0) begin
			cmp_name = name_q.pop_front();
			cmp_exp = exp_q.pop_front();
			cmp_act = act_q.pop_front();
			if (cmp_act !== cmp_exp) begin
				$display("Mismatch %s: expected %h, actual %h", cmp_name, cmp_exp, cmp_act);
				err_cnt++;
			end
		end
	end

	function automatic logic [31:0] xorshift();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic logic [15:0] timer_addr(input logic [11:0] ofs);
		return {4'(periph_pkg::WIN_TIMER), ofs};
	endfunction

	function automatic logic [15:0] tb_addr(input logic [11:0] ofs);
		return {4'(periph_pkg::WIN_TIMEBASE), ofs};
	endfunction

	// expected read value from the register model
	function automatic logic [31:0] ref_read(input logic [15:0] addr);
		logic [31:0] val;
		val = '0;
		if (addr[15:12] == 4'(periph_pkg::WIN_TIMER)) begin
			case (addr[11:0])
				periph_pkg::TMR_CTRL:      val = {31'b0, m_en};
				periph_pkg::TMR_MTIME:     val = m_mtime[31:0];
				periph_pkg::TMR_MTIMEH:    val = m_mtime[63:32];
				periph_pkg::TMR_MTIMECMP:  val = m_cmp[31:0];
				periph_pkg::TMR_MTIMECMPH: val = m_cmp[63:32];
				default: val = '0;
			endcase
		end else if (addr == tb_addr(periph_pkg::TB_DIV)) begin
			val = {24'b0, m_div};
		end
		return val;
	endfunction

	// mtime range after n cycles with divider d
	function automatic void ref_mtime_bounds(input int n, input int d,
			output logic [63:0] lo, output logic [63:0] hi);
		int q;
		q = n / d;
		lo = (q >= 2) ? 64'(q - 2) : 64'd0;
		hi = 64'(q + 1);
	endfunction

	task automatic model_write(input logic [15:0] addr, input logic [31:0] data);
		if (addr[15:12] == 4'(periph_pkg::WIN_TIMER)) begin
			case (addr[11:0])
				periph_pkg::TMR_CTRL:      m_en = data[0];
				periph_pkg::TMR_MTIME:     m_mtime[31:0] = data;
				periph_pkg::TMR_MTIMEH:    m_mtime[63:32] = data;
				periph_pkg::TMR_MTIMECMP:  m_cmp[31:0] = data;
				periph_pkg::TMR_MTIMECMPH: m_cmp[63:32] = data;
				default: ;
			endcase
		end else if (addr == tb_addr(periph_pkg::TB_DIV)) begin
			m_div = data[7:0];
		end
	endtask

	// ---------------------------------------------------------------------
	// APB driver
	// ---------------------------------------------------------------------
	task automatic apb_xfer(input logic wr, input logic [15:0] addr, input logic [31:0] wdata);
		int waits;
		@(negedge clk);
		req = '{sel: 1'b1, enable: 1'b0, write: wr, addr: addr, wdata: wdata};
		@(negedge clk);
		req.enable = 1'b1;
		waits = 0;
		#(CLK_PERIOD / 4);
		while (!rsp.ready) begin
			@(negedge clk);
			#(CLK_PERIOD / 4);
			waits++;
		end
		xfer_rdata = rsp.rdata;
		xfer_err = rsp.slverr;
		// no wait states expected from any slave
		expect_value("wait states", 64'd0, 64'(waits));
		@(negedge clk);
		req = '0;
	endtask

	task automatic apb_write(input logic [15:0] addr, input logic [31:0] data);
		apb_xfer(1'b1, addr, data);
		model_write(addr, data);
	endtask

	task automatic apb_read(input logic [15:0] addr, output logic [31:0] data);
		apb_xfer(1'b0, addr, 32'b0);
		data = xfer_rdata;
	endtask

	task automatic read_mtime(output logic [63:0] value);
		logic [31:0] lo;
		logic [31:0] hi;
		apb_read(timer_addr(periph_pkg::TMR_MTIME), lo);
		apb_read(timer_addr(periph_pkg::TMR_MTIMEH), hi);
		value = {hi, lo};
	endtask

	task automatic expect_value(input string what, input logic [63:0] exp, input logic [63:0] act);
		name_q.push_back({cur_test, "/", what});
		exp_q.push_back(exp);
		act_q.push_back(act);
		check_cnt++;
	endtask

	task automatic check_read(input logic [15:0] addr, input string what);
		logic [31:0] data;
		apb_read(addr, data);
		expect_value(what, {32'b0, ref_read(addr)}, {32'b0, data});
		expect_value({what, " slverr"}, 64'd0, {63'b0, xfer_err});
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		err_start = err_cnt;
	endtask

	task automatic end_test();
		@(posedge clk);
		@(negedge clk);
		test_cnt++;
		if (err_cnt != err_start) begin
			test_fail++;
			$display("test %s: FAIL, %0d errors", cur_test, err_cnt - err_start);
		end else begin
			$display("test %s: ok", cur_test);
		end
	endtask

	// ---------------------------------------------------------------------
	// tests
	// ---------------------------------------------------------------------
	initial begin
		logic [31:0] rd;
		logic [31:0] rnd;
		logic [7:0]  div_val;
		logic [63:0] mt;
		logic [63:0] mt_b;
		logic [63:0] lo_b;
		logic [63:0] hi_b;
		logic [63:0] cmp_val;
		int          waited;
		cycles = 0;
		err_cnt = 0;
		check_cnt = 0;
		test_cnt = 0;
		test_fail = 0;
		rng_state = 32'd67747;
		req = '0;
		rst_n = 1'b0;
		// halted so mtime stays at its reset value
		dbg_halt = 1'b1;
		m_en = 1'b1;
		m_mtime = '0;
		m_cmp = '1;
		m_div = periph_pkg::DIV_RESET;
		repeat (RST_CYC) @(negedge clk);
		rst_n = 1'b1;

		begin_test("reset_readback");
		check_read(timer_addr(periph_pkg::TMR_CTRL), "ctrl");
		check_read(timer_addr(periph_pkg::TMR_MTIME), "mtime");
		check_read(timer_addr(periph_pkg::TMR_MTIMEH), "mtimeh");
		check_read(timer_addr(periph_pkg::TMR_MTIMECMP), "mtimecmp");
		check_read(timer_addr(periph_pkg::TMR_MTIMECMPH), "mtimecmph");
		check_read(timer_addr(12'h004), "unknown offset");
		check_read(tb_addr(periph_pkg::TB_DIV), "div");
		apb_write(timer_addr(periph_pkg::TMR_MTIMECMP), xorshift());
		apb_write(timer_addr(periph_pkg::TMR_MTIMECMPH), xorshift());
		apb_write(timer_addr(periph_pkg::TMR_CTRL), xorshift());
		apb_write(tb_addr(periph_pkg::TB_DIV), xorshift());
		check_read(timer_addr(periph_pkg::TMR_MTIMECMP), "mtimecmp written");
		check_read(timer_addr(periph_pkg::TMR_MTIMECMPH), "mtimecmph written");
		check_read(timer_addr(periph_pkg::TMR_CTRL), "ctrl written");
		check_read(tb_addr(periph_pkg::TB_DIV), "div written");
		end_test();

		begin_test("unmapped");
		apb_read(16'h2008, rd);
		expect_value("read slverr", 64'd1, {63'b0, xfer_err});
		expect_value("read rdata", 64'd0, {32'b0, rd});
		apb_write(16'hf010, xorshift());
		expect_value("write slverr", 64'd1, {63'b0, xfer_err});
		expect_value("write rdata", 64'd0, {32'b0, xfer_rdata});
		check_read(timer_addr(periph_pkg::TMR_CTRL), "ctrl");
		check_read(timer_addr(periph_pkg::TMR_MTIME), "mtime");
		check_read(timer_addr(periph_pkg::TMR_MTIMECMP), "mtimecmp");
		check_read(timer_addr(periph_pkg::TMR_MTIMECMPH), "mtimecmph");
		end_test();

		begin_test("counting");
		rnd = xorshift();
		div_val = {5'b0, rnd[2:0]} + 8'd1;
		apb_write(tb_addr(periph_pkg::TB_DIV), {24'b0, div_val});
		// old divider may still be counting down
		repeat (DRAIN_CYC) @(negedge clk);
		apb_write(timer_addr(periph_pkg::TMR_MTIME), 32'd0);
		apb_write(timer_addr(periph_pkg::TMR_MTIMEH), 32'd0);
		apb_write(timer_addr(periph_pkg::TMR_CTRL), 32'd1);
		dbg_halt = 1'b0;
		// low word sampled COUNT_N cycles after release
		repeat (COUNT_N - 2) @(negedge clk);
		read_mtime(mt);
		ref_mtime_bounds(COUNT_N, int'(div_val), lo_b, hi_b);
		if (mt < lo_b || mt > hi_b) begin
			$display("Mismatch counting/mtime: expected %0d to %0d, actual %0d", lo_b, hi_b, mt);
			err_cnt++;
		end
		end_test();

		begin_test("halt_disable");
		dbg_halt = 1'b1;
		read_mtime(mt);
		repeat (HOLD_CYC) @(negedge clk);
		read_mtime(mt_b);
		expect_value("mtime halted", mt, mt_b);
		apb_write(timer_addr(periph_pkg::TMR_CTRL), 32'd0);
		dbg_halt = 1'b0;
		read_mtime(mt);
		repeat (HOLD_CYC) @(negedge clk);
		read_mtime(mt_b);
		expect_value("mtime disabled", mt, mt_b);
		apb_write(timer_addr(periph_pkg::TMR_CTRL), 32'd1);
		repeat (RESUME_CYC) @(negedge clk);
		read_mtime(mt);
		if (mt <= mt_b) begin
			$display("Mismatch halt_disable/resume: expected above %h, actual %h", mt_b, mt);
			err_cnt++;
		end
		end_test();

		begin_test("interrupt");
		read_mtime(mt);
		cmp_val = mt + 64'(CMP_OFFSET);
		// high word first so no early match on the way
		apb_write(timer_addr(periph_pkg::TMR_MTIMECMPH), 32'hffff_ffff);
		apb_write(timer_addr(periph_pkg::TMR_MTIMECMP), cmp_val[31:0]);
		apb_write(timer_addr(periph_pkg::TMR_MTIMECMPH), cmp_val[63:32]);
		waited = 0;
		while (!timer_irq && waited < IRQ_WAIT) begin
			@(negedge clk);
			waited++;
		end
		if (!timer_irq) begin
			$display("interrupt: timer_irq did not rise within %0d cycles", IRQ_WAIT);
			err_cnt++;
		end
		read_mtime(mt);
		if (mt < cmp_val) begin
			$display("Mismatch interrupt/mtime: expected at least %h, actual %h", cmp_val, mt);
			err_cnt++;
		end
		apb_write(timer_addr(periph_pkg::TMR_MTIMECMPH), 32'hffff_ffff);
		repeat (2) @(negedge clk);
		expect_value("irq cleared", 64'd0, {63'b0, timer_irq});
		end_test();

		$display("tests: %0d run, %0d failed; checks: %0d; errors: %0d",
			test_cnt, test_fail, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: periph_subsys.f
logic/periph_pkg.sv
logic/apb_decoder.sv
logic/timebase.sv
logic/mtimer.sv
logic/periph_subsys.sv
test/tb_periph_subsys.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_periph_subsys \
	-f periph_subsys.f --Mdir obj_dir -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1
